//--- compile.f
src/gpu_cmd_pkg.sv
src/gpu_mem_pkg.sv
src/gpu_draw_ctrl.sv
src/rect_walker.sv
src/texel_fetch.sv
src/palette_lookup.sv
src/gpu_top.sv
testbench/gpu_tb_models.sv
testbench/gpu_top_asserts.sv
testbench/gpu_tb.sv

//--- testbench/gpu_tb.sv
`timescale 1ns/1ps

module gpu_tb
    import gpu_cmd_pkg::*, gpu_mem_pkg::*;
();

    localparam int          FB_WIDTH     = 400;
    localparam int          FB_HEIGHT    = 240;
    localparam int          BUSY_TIMEOUT = 5000;
    localparam int unsigned SEED         = 91;

    logic                clk;
    logic                rst;
    logic                command_draw;
    logic [ADDR_W-1:0]   image_start;
    logic [COORD_W-1:0]  image_width;
    logic [COORD_W-1:0]  image_x;
    logic [COORD_W-1:0]  image_y;
    logic [COORD_W-1:0]  screen_x;
    logic [COORD_W-1:0]  screen_y;
    logic [COORD_W-1:0]  excerpt_width;
    logic [COORD_W-1:0]  excerpt_height;
    logic                image_flip_x;
    logic                image_flip_y;
    ct_type_e            ct_type;
    logic                ct_enable;
    logic [COLOUR_W-1:0] ct_offset;
    logic [COLOUR_W-1:0] draw_colour;
    colour_source_e      draw_colour_source;
    logic [ADDR_W-1:0]   m_axil_araddr;
    logic                m_axil_arvalid;
    logic                m_axil_arready;
    logic [DATA_W-1:0]   m_axil_rdata;
    logic                m_axil_rvalid;
    logic                m_axil_rready;
    logic [COLOUR_W-1:0] ct_address;
    logic [COLOUR_W-1:0] ct_colour;
    logic                is_busy;
    logic [COORD_W-1:0]  fb_x;
    logic [COORD_W-1:0]  fb_y;
    logic [COLOUR_W-1:0] fb_colour;
    logic                fb_write;

    int       write_count;
    int       count_errors = 0;
    bit       timed_out    = 1'b0;
    ct_type_e depths[5]    = '{BPP_1, BPP_2, BPP_4, BPP_8, BPP_16};

    gpu_top #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) gpu_top_inst (.*);

    gpu_tb_models #(
        .SEED (SEED)
    ) models_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        if (fb_write) begin
            write_count++;
        end
    end

    // Walk stops at the first clipped pixel in raster order
    function automatic int expected_writes();
        if (excerpt_width == 0 || excerpt_height == 0) begin
            return 0;
        end
        if (screen_x >= FB_WIDTH || screen_y >= FB_HEIGHT) begin
            return 0;
        end
        if (screen_x + excerpt_width > FB_WIDTH) begin
            return FB_WIDTH - screen_x;
        end
        if (screen_y + excerpt_height > FB_HEIGHT) begin
            return excerpt_width * (FB_HEIGHT - screen_y);
        end
        return excerpt_width * excerpt_height;
    endfunction

    task automatic load_defaults();
        image_start        = 32'h0000_1000;
        image_width        = 16'd64;
        image_x            = '0;
        image_y            = '0;
        image_flip_x       = 1'b0;
        image_flip_y       = 1'b0;
        ct_type            = BPP_8;
        ct_enable          = 1'b0;
        ct_offset          = '0;
        draw_colour        = '0;
        draw_colour_source = SRC_MEMORY;
    endtask

    task automatic place_rect(input int x, input int y, input int w, input int h);
        screen_x       = COORD_W'(x);
        screen_y       = COORD_W'(y);
        excerpt_width  = COORD_W'(w);
        excerpt_height = COORD_W'(h);
    endtask

    task automatic draw_rect();
        int cycles;
        int exp_writes;
        if (timed_out) begin
            return;
        end
        exp_writes   = expected_writes();
        write_count  = 0;
        command_draw = 1'b1;
        @(negedge clk);
        command_draw = 1'b0;
        cycles = 0;
        while (is_busy && cycles < BUSY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (is_busy) begin
            $display("Timeout: is_busy still high after %0d cycles", cycles);
            timed_out = 1'b1;
        end else begin
            assert (write_count == exp_writes) else begin
                count_errors++;
                $display("CHECK FAILED write_count got %h expected %h", write_count, exp_writes);
            end
        end
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = gpu_top_inst.asserts_inst.fail_count;
        $display("Errors: write count %0d, assertions %0d, timeouts %0d",
            count_errors, assert_errors, timed_out);
        if (count_errors == 0 && assert_errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    initial begin
        rst          = 1'b1;
        command_draw = 1'b0;
        load_defaults();
        place_rect(0, 0, 1, 1);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        draw_colour_source = SRC_COLOUR;  // Solid fill
        draw_colour        = 16'hBEEF;
        place_rect(10, 20, 5, 3);
        draw_rect();

        // Runs of pixels share a word at low depths
        foreach (depths[k]) begin
            load_defaults();
            ct_type = depths[k];
            image_x = 16'd3;
            image_y = 16'd2;
            place_rect(30, 40, 20, 3);
            draw_rect();
        end

        load_defaults();
        ct_type   = BPP_4;
        ct_enable = 1'b1;
        ct_offset = 16'h0100;
        place_rect(50, 60, 12, 2);
        draw_rect();

        load_defaults();
        ct_type      = BPP_2;
        image_flip_x = 1'b1;
        image_flip_y = 1'b1;
        image_x      = 16'd5;
        image_y      = 16'd1;
        place_rect(100, 100, 7, 4);
        draw_rect();

        load_defaults();
        image_flip_x = 1'b1;
        place_rect(FB_WIDTH - 4, 8, 10, 3);  // Right edge
        draw_rect();

        load_defaults();
        draw_colour_source = SRC_COLOUR;
        draw_colour        = 16'h0F0F;
        place_rect(0, FB_HEIGHT - 2, 3, 5);
        draw_rect();

        place_rect(10, 10, 0, 4);
        draw_rect();
        place_rect(FB_WIDTH, 0, 3, 3);  // First pixel already off screen
        draw_rect();

        finish_run();
    end

endmodule

//--- testbench/gpu_top_asserts.sv
`timescale 1ns/1ps

module gpu_top_asserts
    import gpu_cmd_pkg::*, gpu_mem_pkg::*;
#(
    parameter int FB_WIDTH  = 400,
    parameter int FB_HEIGHT = 240
) (
    input logic                clk,
    input logic                rst,
    input logic                command_draw,
    input logic [ADDR_W-1:0]   image_start,
    input logic [COORD_W-1:0]  image_width,
    input logic [COORD_W-1:0]  image_x,
    input logic [COORD_W-1:0]  image_y,
    input logic [COORD_W-1:0]  screen_x,
    input logic [COORD_W-1:0]  screen_y,
    input logic [COORD_W-1:0]  excerpt_width,
    input logic [COORD_W-1:0]  excerpt_height,
    input logic                image_flip_x,
    input logic                image_flip_y,
    input ct_type_e            ct_type,
    input logic                ct_enable,
    input logic [COLOUR_W-1:0] ct_offset,
    input logic [COLOUR_W-1:0] draw_colour,
    input colour_source_e      draw_colour_source,
    input logic [ADDR_W-1:0]   m_axil_araddr,
    input logic                m_axil_arvalid,
    input logic                m_axil_arready,
    input logic                m_axil_rvalid,
    input logic                m_axil_rready,
    input logic                is_busy,
    input logic [COORD_W-1:0]  fb_x,
    input logic [COORD_W-1:0]  fb_y,
    input logic [COLOUR_W-1:0] fb_colour,
    input logic                fb_write
);

    int                  fail_count = 0;
    logic [COORD_W-1:0]  exp_i;  // Rectangle offset of the next write
    logic [COORD_W-1:0]  exp_j;
    logic [COORD_W-1:0]  exp_x;
    logic [COORD_W-1:0]  exp_y;
    logic [COLOUR_W-1:0] exp_colour;

    function automatic logic [COLOUR_W-1:0] expected_colour(
        input logic [COORD_W-1:0] i,
        input logic [COORD_W-1:0] j
    );
        int unsigned       sx;
        int unsigned       sy;
        int unsigned       bit_pos;
        int unsigned       field;
        logic [ADDR_W-1:0] sheet_word;
        if (draw_colour_source == SRC_COLOUR) begin
            return draw_colour;
        end
        sx = image_x + (image_flip_x ? excerpt_width - 1 - i : i);
        sy = image_y + (image_flip_y ? excerpt_height - 1 - j : j);
        bit_pos = (sx + image_width * sy) * ct_type;
        // Read slave returns the word address as data
        sheet_word = image_start + (bit_pos / 8) / WORD_BYTES * WORD_BYTES;
        field = (sheet_word >> (bit_pos % DATA_W)) & ((32'd1 << ct_type) - 1);
        if (ct_enable) begin
            return COLOUR_W'((field * 2 + ct_offset) ^ 32'hA5A5);
        end
        return COLOUR_W'(field);
    endfunction

    always_ff @(posedge clk) begin
        if (rst || (command_draw && !is_busy)) begin
            exp_i <= '0;
            exp_j <= '0;
        end else if (fb_write) begin
            if (exp_i == excerpt_width - 1'b1) begin
                exp_i <= '0;
                exp_j <= exp_j + 1'b1;
            end else begin
                exp_i <= exp_i + 1'b1;
            end
        end
    end

    always_comb begin
        exp_x      = screen_x + exp_i;
        exp_y      = screen_y + exp_j;
        exp_colour = expected_colour(exp_i, exp_j);
    end

    reset_quiet: assert property (@(posedge clk)
        rst |=> !is_busy && !fb_write && !m_axil_arvalid && !m_axil_rready)
        else begin
            fail_count++;
            $error("Outputs not idle after reset");
        end

    write_busy: assert property (@(posedge clk) disable iff (rst) fb_write |-> is_busy)
        else begin
            fail_count++;
            $error("fb_write pulsed while is_busy was low");
        end

    write_x: assert property (@(posedge clk) disable iff (rst) fb_write |-> fb_x == exp_x)
        else begin
            fail_count++;
            $error("CHECK FAILED fb_x got %h expected %h", $sampled(fb_x), $sampled(exp_x));
        end

    write_y: assert property (@(posedge clk) disable iff (rst) fb_write |-> fb_y == exp_y)
        else begin
            fail_count++;
            $error("CHECK FAILED fb_y got %h expected %h", $sampled(fb_y), $sampled(exp_y));
        end

    write_inside: assert property (@(posedge clk) disable iff (rst)
        fb_write |-> exp_j < excerpt_height && fb_x < FB_WIDTH && fb_y < FB_HEIGHT)
        else begin
            fail_count++;
            $error("Write outside the rectangle or the framebuffer");
        end

    write_colour: assert property (@(posedge clk) disable iff (rst)
        fb_write |-> fb_colour == exp_colour)
        else begin
            fail_count++;
            $error("CHECK FAILED fb_colour got %h expected %h",
                $sampled(fb_colour), $sampled(exp_colour));
        end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        m_axil_arvalid && !m_axil_arready |=> m_axil_arvalid && $stable(m_axil_araddr))
        else begin
            fail_count++;
            $error("arvalid dropped or araddr changed before arready");
        end

    ar_aligned: assert property (@(posedge clk) disable iff (rst)
        m_axil_arvalid |-> m_axil_araddr % WORD_BYTES == 0)
        else begin
            fail_count++;
            $error("CHECK FAILED m_axil_araddr got %h, not word aligned", $sampled(m_axil_araddr));
        end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        m_axil_rready && !m_axil_rvalid |=> m_axil_rready)
        else begin
            fail_count++;
            $error("rready dropped before rvalid");
        end

endmodule

bind gpu_top gpu_top_asserts #(
    .FB_WIDTH  (FB_WIDTH),
    .FB_HEIGHT (FB_HEIGHT)
) asserts_inst (.*);

//--- testbench/gpu_tb_models.sv
`timescale 1ns/1ps

module gpu_tb_models
    import gpu_cmd_pkg::*, gpu_mem_pkg::*;
#(
    parameter int unsigned SEED = 91
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [ADDR_W-1:0]   m_axil_araddr,
    input  logic                m_axil_arvalid,
    output logic                m_axil_arready,
    output logic [DATA_W-1:0]   m_axil_rdata,
    output logic                m_axil_rvalid,
    input  logic                m_axil_rready,
    input  logic [COLOUR_W-1:0] ct_address,
    output logic [COLOUR_W-1:0] ct_colour
);

    localparam int READY_LIMIT = 64;

    // AXI-Lite read slave, data echoes the word address
    initial begin
        int guard;
        void'($urandom(SEED));
        m_axil_arready = 1'b0;
        m_axil_rvalid  = 1'b0;
        m_axil_rdata   = '0;
        forever begin
            @(negedge clk);
            if (!rst && m_axil_arvalid) begin
                repeat ($urandom % 4) @(negedge clk);  // Address back-pressure
                m_axil_arready = 1'b1;
                m_axil_rdata   = m_axil_araddr;
                @(negedge clk);
                m_axil_arready = 1'b0;
                repeat ($urandom % 4) @(negedge clk);
                m_axil_rvalid = 1'b1;
                guard = 0;
                // rready drops once the beat is taken
                do begin
                    @(negedge clk);
                    guard++;
                end while (m_axil_rready && guard < READY_LIMIT);
                m_axil_rvalid = 1'b0;
            end
        end
    end

    // Colour table, one cycle of latency
    initial begin
        logic [COLOUR_W-1:0] addr_seen;
        addr_seen = '0;
        ct_colour = '0;
        forever begin
            @(negedge clk);
            ct_colour = addr_seen ^ 16'hA5A5;
            addr_seen = ct_address;
        end
    end

endmodule

//--- src/gpu_top.sv
`timescale 1ns/1ps

module gpu_top
    import gpu_cmd_pkg::*, gpu_mem_pkg::*;
#(
    parameter int FB_WIDTH  = 400,
    parameter int FB_HEIGHT = 240
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                command_draw,
    input  logic [ADDR_W-1:0]   image_start,
    input  logic [COORD_W-1:0]  image_width,
    input  logic [COORD_W-1:0]  image_x,
    input  logic [COORD_W-1:0]  image_y,
    input  logic [COORD_W-1:0]  screen_x,
    input  logic [COORD_W-1:0]  screen_y,
    input  logic [COORD_W-1:0]  excerpt_width,
    input  logic [COORD_W-1:0]  excerpt_height,
    input  logic                image_flip_x,
    input  logic                image_flip_y,
    input  ct_type_e            ct_type,
    input  logic                ct_enable,
    input  logic [COLOUR_W-1:0] ct_offset,
    input  logic [COLOUR_W-1:0] draw_colour,
    input  colour_source_e      draw_colour_source,

    // AXI-Lite read master
    output logic [ADDR_W-1:0]   m_axil_araddr,
    output logic                m_axil_arvalid,
    input  logic                m_axil_arready,
    input  logic [DATA_W-1:0]   m_axil_rdata,
    input  logic                m_axil_rvalid,
    output logic                m_axil_rready,

    output logic [COLOUR_W-1:0] ct_address,
    input  logic [COLOUR_W-1:0] ct_colour,

    output logic                is_busy,
    output logic [COORD_W-1:0]  fb_x,
    output logic [COORD_W-1:0]  fb_y,
    output logic [COLOUR_W-1:0] fb_colour,
    output logic                fb_write
);

    logic                walk_start;
    logic                walk_step;
    logic                walk_valid;
    logic [COORD_W-1:0]  pix_x;
    logic [COORD_W-1:0]  pix_y;
    logic [ADDR_W-1:0]   bit_addr;
    logic                fetch_start;
    logic                fetch_done;
    logic [COLOUR_W-1:0] texel;
    logic                lookup_start;
    logic                lookup_done;
    logic [COLOUR_W-1:0] ct_colour_q;

    gpu_draw_ctrl ctrl_inst (
        .clk                (clk),
        .rst                (rst),
        .command_draw       (command_draw),
        .draw_colour_source (draw_colour_source),
        .ct_enable          (ct_enable),
        .draw_colour        (draw_colour),
        .walk_valid         (walk_valid),
        .pix_x              (pix_x),
        .pix_y              (pix_y),
        .fetch_done         (fetch_done),
        .texel              (texel),
        .lookup_done        (lookup_done),
        .ct_colour_q        (ct_colour_q),
        .walk_start         (walk_start),
        .walk_step          (walk_step),
        .fetch_start        (fetch_start),
        .lookup_start       (lookup_start),
        .is_busy            (is_busy),
        .fb_x               (fb_x),
        .fb_y               (fb_y),
        .fb_colour          (fb_colour),
        .fb_write           (fb_write)
    );

    rect_walker #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) walker_inst (
        .clk            (clk),
        .rst            (rst),
        .walk_start     (walk_start),
        .walk_step      (walk_step),
        .image_x        (image_x),
        .image_y        (image_y),
        .image_width    (image_width),
        .ct_type        (ct_type),
        .screen_x       (screen_x),
        .screen_y       (screen_y),
        .excerpt_width  (excerpt_width),
        .excerpt_height (excerpt_height),
        .image_flip_x   (image_flip_x),
        .image_flip_y   (image_flip_y),
        .walk_valid     (walk_valid),
        .pix_x          (pix_x),
        .pix_y          (pix_y),
        .bit_addr       (bit_addr)
    );

    texel_fetch fetch_inst (
        .clk            (clk),
        .rst            (rst),
        .walk_start     (walk_start),
        .fetch_start    (fetch_start),
        .image_start    (image_start),
        .bit_addr       (bit_addr),
        .ct_type        (ct_type),
        .m_axil_arready (m_axil_arready),
        .m_axil_rdata   (m_axil_rdata),
        .m_axil_rvalid  (m_axil_rvalid),
        .m_axil_araddr  (m_axil_araddr),
        .m_axil_arvalid (m_axil_arvalid),
        .m_axil_rready  (m_axil_rready),
        .fetch_done     (fetch_done),
        .texel          (texel)
    );

    palette_lookup lookup_inst (
        .clk          (clk),
        .rst          (rst),
        .lookup_start (lookup_start),
        .texel        (texel),
        .ct_offset    (ct_offset),
        .ct_colour    (ct_colour),
        .ct_address   (ct_address),
        .lookup_done  (lookup_done),
        .ct_colour_q  (ct_colour_q)
    );

endmodule

//--- src/palette_lookup.sv
`timescale 1ns/1ps

module palette_lookup
    import gpu_cmd_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                lookup_start,
    input  logic [COLOUR_W-1:0] texel,
    input  logic [COLOUR_W-1:0] ct_offset,
    input  logic [COLOUR_W-1:0] ct_colour,
    output logic [COLOUR_W-1:0] ct_address,
    output logic                lookup_done,
    output logic [COLOUR_W-1:0] ct_colour_q
);

    logic [1:0]          start_pipe;
    logic [COLOUR_W-1:0] colour_hold;

    // Two table entries per texel
    always_ff @(posedge clk) begin
        if (lookup_start) begin
            ct_address <= {texel[COLOUR_W-2:0], 1'b0} + ct_offset;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start_pipe <= '0;
        end else begin
            start_pipe <= {start_pipe[0], lookup_start};
        end
    end

    assign lookup_done = start_pipe[1];  // Table data arrives here

    always_ff @(posedge clk) begin
        if (lookup_done) begin
            colour_hold <= ct_colour;
        end
    end

    // Bypass on arrival, held afterwards
    assign ct_colour_q = lookup_done ? ct_colour : colour_hold;

endmodule

//--- src/texel_fetch.sv
`timescale 1ns/1ps

module texel_fetch
    import gpu_cmd_pkg::*, gpu_mem_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                walk_start,
    input  logic                fetch_start,
    input  logic [ADDR_W-1:0]   image_start,
    input  logic [ADDR_W-1:0]   bit_addr,
    input  ct_type_e            ct_type,
    input  logic                m_axil_arready,
    input  logic [DATA_W-1:0]   m_axil_rdata,
    input  logic                m_axil_rvalid,
    output logic [ADDR_W-1:0]   m_axil_araddr,
    output logic                m_axil_arvalid,
    output logic                m_axil_rready,
    output logic                fetch_done,
    output logic [COLOUR_W-1:0] texel
);

    localparam int OFFSET_W = $clog2(DATA_W);

    fetch_state_e      state;
    logic [ADDR_W-1:0] word_addr;
    logic [ADDR_W-1:0] cache_addr;
    logic [DATA_W-1:0] cache_data;
    logic              cache_valid;
    logic              cache_hit;
    logic              read_done;

    // Pixel field, LSB first within the word
    function automatic logic [COLOUR_W-1:0] extract(
        input logic [DATA_W-1:0]   word,
        input logic [OFFSET_W-1:0] offset,
        input ct_type_e            bpp
    );
        logic [DATA_W-1:0] mask;
        mask = (DATA_W'(1) << bpp) - 1'b1;
        return COLOUR_W'((word >> offset) & mask);
    endfunction

    assign word_addr  = image_start + ((bit_addr >> 3) & ~ADDR_W'(WORD_BYTES - 1));
    assign cache_hit  = cache_valid && (cache_addr == word_addr);
    assign read_done  = (state == FETCH_DATA) && m_axil_rvalid;
    assign fetch_done = (state == FETCH_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= FETCH_IDLE;
            m_axil_arvalid <= 1'b0;
            m_axil_rready  <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (fetch_start) begin
                        if (cache_hit) begin
                            state <= FETCH_DONE;
                        end else begin
                            m_axil_araddr  <= word_addr;
                            m_axil_arvalid <= 1'b1;
                            state          <= FETCH_ADDR;
                        end
                    end
                end
                FETCH_ADDR: begin
                    if (m_axil_arready) begin
                        m_axil_arvalid <= 1'b0;
                        m_axil_rready  <= 1'b1;
                        state          <= FETCH_DATA;
                    end
                end
                FETCH_DATA: begin
                    if (m_axil_rvalid) begin
                        m_axil_rready <= 1'b0;
                        state         <= FETCH_DONE;
                    end
                end
                FETCH_DONE: state <= FETCH_IDLE;
                default:    state <= FETCH_IDLE;
            endcase
        end
    end

    // New rectangle may point at a different sheet
    always_ff @(posedge clk) begin
        if (rst || walk_start) begin
            cache_valid <= 1'b0;
        end else if (read_done) begin
            cache_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_IDLE && fetch_start && cache_hit) begin
            texel <= extract(cache_data, bit_addr[OFFSET_W-1:0], ct_type);
        end
        if (read_done) begin
            cache_addr <= m_axil_araddr;
            cache_data <= m_axil_rdata;
            texel      <= extract(m_axil_rdata, bit_addr[OFFSET_W-1:0], ct_type);
        end
    end

endmodule

//--- src/rect_walker.sv
`timescale 1ns/1ps

module rect_walker
    import gpu_cmd_pkg::*, gpu_mem_pkg::*;
#(
    parameter int FB_WIDTH  = 400,
    parameter int FB_HEIGHT = 240
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               walk_start,
    input  logic               walk_step,
    input  logic [COORD_W-1:0] image_x,
    input  logic [COORD_W-1:0] image_y,
    input  logic [COORD_W-1:0] image_width,
    input  ct_type_e           ct_type,
    input  logic [COORD_W-1:0] screen_x,
    input  logic [COORD_W-1:0] screen_y,
    input  logic [COORD_W-1:0] excerpt_width,
    input  logic [COORD_W-1:0] excerpt_height,
    input  logic               image_flip_x,
    input  logic               image_flip_y,
    output logic               walk_valid,
    output logic [COORD_W-1:0] pix_x,
    output logic [COORD_W-1:0] pix_y,
    output logic [ADDR_W-1:0]  bit_addr
);

    logic [COORD_W-1:0] col;
    logic [COORD_W-1:0] row;
    logic               last_col;
    logic [COORD_W-1:0] next_col;
    logic [COORD_W-1:0] next_row;
    logic [COORD_W-1:0] src_x;
    logic [COORD_W-1:0] src_y;
    logic [ADDR_W-1:0]  sprite_index;

    // Framebuffer position of a rectangle offset, without wrap
    function automatic logic on_screen(
        input logic [COORD_W-1:0] cx,
        input logic [COORD_W-1:0] cy
    );
        logic [COORD_W:0] fx;
        logic [COORD_W:0] fy;
        fx = {1'b0, screen_x} + {1'b0, cx};
        fy = {1'b0, screen_y} + {1'b0, cy};
        return (fx < FB_WIDTH) && (fy < FB_HEIGHT);
    endfunction

    assign last_col = (col == excerpt_width - 1'b1);
    assign next_col = last_col ? '0 : col + 1'b1;
    assign next_row = last_col ? row + 1'b1 : row;

    always_ff @(posedge clk) begin
        if (rst) begin
            walk_valid <= 1'b0;
            col        <= '0;
            row        <= '0;
        end else if (walk_start) begin
            col        <= '0;
            row        <= '0;
            walk_valid <= (excerpt_width != '0) && (excerpt_height != '0) && on_screen('0, '0);
        end else if (walk_step) begin
            col <= next_col;
            row <= next_row;
            // Clipping ends the walk, not just the row
            walk_valid <= (next_row < excerpt_height) && on_screen(next_col, next_row);
        end
    end

    assign pix_x = screen_x + col;
    assign pix_y = screen_y + row;

    assign src_x = image_x + (image_flip_x ? excerpt_width - 1'b1 - col : col);
    assign src_y = image_y + (image_flip_y ? excerpt_height - 1'b1 - row : row);

    assign sprite_index = ADDR_W'(src_x) + ADDR_W'(image_width) * ADDR_W'(src_y);
    assign bit_addr     = sprite_index * ADDR_W'(ct_type);

endmodule

//--- src/gpu_draw_ctrl.sv
`timescale 1ns/1ps

module gpu_draw_ctrl
    import gpu_cmd_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic                command_draw,
    input  colour_source_e      draw_colour_source,
    input  logic                ct_enable,
    input  logic [COLOUR_W-1:0] draw_colour,

    input  logic                walk_valid,
    input  logic [COORD_W-1:0]  pix_x,
    input  logic [COORD_W-1:0]  pix_y,
    input  logic                fetch_done,
    input  logic [COLOUR_W-1:0] texel,
    input  logic                lookup_done,
    input  logic [COLOUR_W-1:0] ct_colour_q,

    output logic                walk_start,
    output logic                walk_step,
    output logic                fetch_start,
    output logic                lookup_start,

    output logic                is_busy,
    output logic [COORD_W-1:0]  fb_x,
    output logic [COORD_W-1:0]  fb_y,
    output logic [COLOUR_W-1:0] fb_colour,
    output logic                fb_write
);

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_LOAD,
        CTRL_FETCH,
        CTRL_LOOKUP,
        CTRL_WRITE
    } ctrl_state_e;

    ctrl_state_e         state;
    ctrl_state_e         state_next;
    logic [COLOUR_W-1:0] write_colour;  // Colour of the pixel about to be written
    logic                solid;

    assign solid = (draw_colour_source == SRC_COLOUR);

    always_comb begin
        state_next   = state;
        write_colour = draw_colour;
        case (state)
            CTRL_IDLE: begin
                if (command_draw) begin
                    state_next = CTRL_LOAD;
                end
            end
            CTRL_LOAD: begin
                // Walker output for the current pixel is settled here
                if (!walk_valid) begin
                    state_next = CTRL_IDLE;
                end else if (solid) begin
                    state_next = CTRL_WRITE;
                end else begin
                    state_next = CTRL_FETCH;
                end
            end
            CTRL_FETCH: begin
                if (fetch_done) begin
                    if (ct_enable) begin
                        state_next = CTRL_LOOKUP;
                    end else begin
                        state_next   = CTRL_WRITE;
                        write_colour = texel;
                    end
                end
            end
            CTRL_LOOKUP: begin
                if (lookup_done) begin
                    state_next   = CTRL_WRITE;
                    write_colour = ct_colour_q;
                end
            end
            CTRL_WRITE: state_next = CTRL_LOAD;
            default:    state_next = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CTRL_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Framebuffer payload, held for the write cycle
    always_ff @(posedge clk) begin
        if (state != CTRL_WRITE && state_next == CTRL_WRITE) begin
            fb_x      <= pix_x;
            fb_y      <= pix_y;
            fb_colour <= write_colour;
        end
    end

    assign walk_start   = (state == CTRL_IDLE) && command_draw;
    assign walk_step    = (state == CTRL_WRITE);
    assign fetch_start  = (state == CTRL_LOAD) && walk_valid && !solid;
    assign lookup_start = (state == CTRL_FETCH) && fetch_done && ct_enable;

    assign is_busy  = (state != CTRL_IDLE);
    assign fb_write = (state == CTRL_WRITE);  // One pulse per pixel

endmodule

//--- src/gpu_mem_pkg.sv
package gpu_mem_pkg;

    // Byte address into the sprite sheet
    localparam int ADDR_W = 32;

    localparam int DATA_W     = 32;  // AXI-Lite read data
    localparam int WORD_BYTES = DATA_W / 8;

    // Sprite-sheet read sequence
    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA,
        FETCH_DONE
    } fetch_state_e;

endpackage

//--- src/gpu_cmd_pkg.sv
package gpu_cmd_pkg;

    // Coordinates, sizes and image width
    localparam int COORD_W = 16;

    // Colours and colour-table indices
    localparam int COLOUR_W = 16;

    // Bits per sprite-sheet pixel, value is the bit count
    typedef enum logic [4:0] {
        BPP_1  = 5'd1,
        BPP_2  = 5'd2,
        BPP_4  = 5'd4,
        BPP_8  = 5'd8,
        BPP_16 = 5'd16
    } ct_type_e;

    typedef enum logic {
        SRC_MEMORY,
        SRC_COLOUR
    } colour_source_e;

endpackage
